// ==== include/led_ctrl_defs.svh ====
`ifndef LED_CTRL_DEFS_SVH
`define LED_CTRL_DEFS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define LED_DATA_W      32
`define LED_ADDR_W      4    // word address, not byte
`define LED_DIV_W       12
`define LED_SEL_W       4
`define LED_NUM_BLINK   3

// blink timing
`define LED_PRESCALE    4    // clocks per tick, kept short for sim
`define LED_DIV_RESET   9

// fixed build identifier, replaces the old hash
`define LED_BUILD_ID_LO 32'h5eed_0b41
`define LED_BUILD_ID_HI 32'h0001_f7c0

// ----------------------------------------
// register map (word addresses)
// ----------------------------------------
`define LED_ADDR_BUILD_ID_LO 4'd0
`define LED_ADDR_BUILD_ID_HI 4'd1
`define LED_ADDR_DIV0        4'd2
`define LED_ADDR_DIV1        4'd3
`define LED_ADDR_DIV2        4'd4
`define LED_ADDR_LED_SEL     4'd5
`define LED_ADDR_INT_STATUS  4'd6   // write 1 to clear
`define LED_ADDR_INT_EN      4'd7
`define LED_ADDR_YELLOW      4'd8

`endif

// ==== led_ctrl.f ====
+incdir+include
source/led_ctrl_pkg.sv
source/blink_cfg_if.sv
source/led_blinker.sv
source/led_regfile.sv
source/led_ctrl_top.sv
testbench/led_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the led_ctrl testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f led_ctrl.f --top-module led_ctrl_tb -o Vled_ctrl_tb

./obj_dir/Vled_ctrl_tb | tee "$LOG"

if grep -qx 'All tests passed!' "$LOG"; then
  echo "simulation PASSED, log in $LOG"
  exit 0
else
  echo "simulation FAILED, log in $LOG"
  exit 1
fi

// ==== source/blink_cfg_if.sv ====
`timescale 1ns/1ps

// config and status between register file and the blinkers
interface blink_cfg_if
  import led_ctrl_pkg::*;
();

  // divisors, one per blinker
  div_t       div0;
  div_t       div1;
  div_t       div2;

  blink_vec_t wren;     // reload strobes, one cycle each
  blink_vec_t led;      // current led levels
  blink_vec_t led_int;  // on-edge pulses

  // register file side
  modport regs (
    output div0,
    output div1,
    output div2,
    output wren,
    input  led,
    input  led_int
  );

  // blinker side, top hands each blinker its own slice
  modport blink (
    input  div0,
    input  div1,
    input  div2,
    input  wren,
    output led,
    output led_int
  );

endinterface

// ==== source/led_blinker.sv ====
`timescale 1ns/1ps
`include "led_ctrl_defs.svh"

module led_blinker
  import led_ctrl_pkg::*;
(
  input  logic clk100_i,
  input  logic arst_n_i,
  input  div_t div_i,      // sampled on wren_i
  input  logic wren_i,
  output logic led_o,
  output logic led_int_o   // 1 cycle when led turns on
);

  localparam int PRE_W = (`LED_PRESCALE > 1) ? $clog2(`LED_PRESCALE) : 1;

  logic [PRE_W-1:0] pre_cnt_q;
  logic             tick;        // one clock every prescale period
  div_t             div_q;       // latched divisor
  div_t             tick_cnt_q;
  logic             toggle;
  logic             led_q;
  logic             int_q;

  // ----------------------------------------
  // prescaler
  // ----------------------------------------
  assign tick = (pre_cnt_q == PRE_W'(`LED_PRESCALE - 1));

  always_ff @(posedge clk100_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pre_cnt_q <= '0;
    end else if (wren_i || tick) begin
      pre_cnt_q <= '0;  // reload restarts the period
    end else begin
      pre_cnt_q <= pre_cnt_q + 1'b1;
    end
  end

  // ----------------------------------------
  // tick counter and led
  // ----------------------------------------
  // last tick of a half period
  assign toggle = tick && (tick_cnt_q == div_q);

  always_ff @(posedge clk100_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_q      <= div_t'(`LED_DIV_RESET);
      tick_cnt_q <= '0;
      led_q      <= 1'b0;
      int_q      <= 1'b0;
    end else if (wren_i) begin
      div_q      <= div_i;   // new value, restart dark
      tick_cnt_q <= '0;
      led_q      <= 1'b0;
      int_q      <= 1'b0;
    end else begin
      int_q <= toggle && !led_q;  // rising led only
      if (toggle) begin
        tick_cnt_q <= '0;
        led_q      <= !led_q;
      end else if (tick) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
    end
  end

  assign led_o     = led_q;
  assign led_int_o = int_q;

  // the led stays on for at least one tick, so pulses never merge
  a_int_single: assert property (@(posedge clk100_i) disable iff (!arst_n_i)
    led_int_o |=> !led_int_o)
    else $error("led_int_o high for two cycles");

endmodule

// ==== source/led_ctrl_pkg.sv ====
`include "led_ctrl_defs.svh"

package led_ctrl_pkg;

  // ----------------------------------------
  // register port
  // ----------------------------------------
  typedef logic [`LED_DATA_W-1:0] data_t;  // one register word
  typedef logic [`LED_ADDR_W-1:0] addr_t;

  // ----------------------------------------
  // blink side
  // ----------------------------------------
  // reload value, led toggles after div+1 ticks
  typedef logic [`LED_DIV_W-1:0] div_t;

  typedef logic [`LED_SEL_W-1:0] led_sel_t;  // blue led source

  // one bit per blinker
  typedef logic [`LED_NUM_BLINK-1:0] blink_vec_t;

  // four-phase handshake
  typedef enum logic {
    BUS_IDLE,  // waiting for req
    BUS_ACK    // ack held until req drops
  } bus_state_e;

endpackage

// ==== source/led_ctrl_top.sv ====
`timescale 1ns/1ps

module led_ctrl_top
  import led_ctrl_pkg::*;
(
  input  logic       clk100_i,
  input  logic       arst_n_i,
  // register port, four-phase req/ack
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  output logic       ack_o,
  output data_t      rdata_o,
  output logic       irq_o,
  output logic [1:0] radio_led_o  // 1 blue, 0 yellow
);

  // divisors, strobes, levels and pulses
  blink_cfg_if i_cfg ();

  // ----------------------------------------
  // register file
  // ----------------------------------------
  led_regfile i_regfile (
    .clk100_i    (clk100_i    ),
    .arst_n_i    (arst_n_i    ),
    .req_i       (req_i       ),
    .we_i        (we_i        ),
    .addr_i      (addr_i      ),
    .wdata_i     (wdata_i     ),
    .ack_o       (ack_o       ),
    .rdata_o     (rdata_o     ),
    .irq_o       (irq_o       ),
    .radio_led_o (radio_led_o ),
    .cfg         (i_cfg.regs  )
  );

  // ----------------------------------------
  // blinkers, one slice each
  // ----------------------------------------
  led_blinker i_blink0 (
    .clk100_i  (clk100_i         ),
    .arst_n_i  (arst_n_i         ),
    .div_i     (i_cfg.div0       ),
    .wren_i    (i_cfg.wren[0]    ),
    .led_o     (i_cfg.led[0]     ),
    .led_int_o (i_cfg.led_int[0] )
  );

  led_blinker i_blink1 (
    .clk100_i  (clk100_i         ),
    .arst_n_i  (arst_n_i         ),
    .div_i     (i_cfg.div1       ),
    .wren_i    (i_cfg.wren[1]    ),
    .led_o     (i_cfg.led[1]     ),
    .led_int_o (i_cfg.led_int[1] )
  );

  // third channel, also the last blinker on the blue mux
  led_blinker i_blink2 (
    .clk100_i  (clk100_i         ),
    .arst_n_i  (arst_n_i         ),
    .div_i     (i_cfg.div2       ),
    .wren_i    (i_cfg.wren[2]    ),
    .led_o     (i_cfg.led[2]     ),
    .led_int_o (i_cfg.led_int[2] )
  );

endmodule

// ==== source/led_regfile.sv ====
`timescale 1ns/1ps
`include "led_ctrl_defs.svh"

module led_regfile
  import led_ctrl_pkg::*;
(
  input  logic       clk100_i,
  input  logic       arst_n_i,
  // four-phase register port
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  output logic       ack_o,
  output data_t      rdata_o,     // valid while ack_o high
  output logic       irq_o,
  output logic [1:0] radio_led_o, // 1 blue, 0 yellow
  blink_cfg_if.regs  cfg
);

  bus_state_e state_q;
  logic       access;          // first cycle of a request
  logic       wr_en;
  blink_vec_t wr_div;          // divisor write, per channel
  blink_vec_t wren_q;
  div_t       div_q [`LED_NUM_BLINK];
  led_sel_t   led_sel_q;
  blink_vec_t int_status_q;
  blink_vec_t int_en_q;
  blink_vec_t int_clr;
  logic       yellow_q;
  logic       irq_q;
  data_t      rd_data;
  data_t      rdata_q;
  logic       blue;

  // ----------------------------------------
  // handshake FSM
  // ----------------------------------------
  always_ff @(posedge clk100_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BUS_IDLE;
    end else begin
      case (state_q)
        BUS_IDLE: if (req_i) state_q <= BUS_ACK;
        BUS_ACK:  if (!req_i) state_q <= BUS_IDLE;  // master let go
        default:  state_q <= BUS_IDLE;
      endcase
    end
  end

  // exactly one access, held req does nothing more
  assign access = (state_q == BUS_IDLE) && req_i;
  assign wr_en  = access && we_i;
  assign ack_o  = (state_q == BUS_ACK);

  // ----------------------------------------
  // write decode
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < `LED_NUM_BLINK; i++) begin
      wr_div[i] = wr_en && (addr_i == addr_t'(`LED_ADDR_DIV0 + i));
    end
  end

  // write-1-to-clear mask
  assign int_clr = (wr_en && addr_i == `LED_ADDR_INT_STATUS) ?
                   wdata_i[`LED_NUM_BLINK-1:0] : '0;

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk100_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `LED_NUM_BLINK; i++) begin
        div_q[i] <= div_t'(`LED_DIV_RESET);
      end
      wren_q       <= '0;
      led_sel_q    <= '0;
      int_status_q <= '0;
      int_en_q     <= '0;
      yellow_q     <= 1'b0;
      irq_q        <= 1'b0;
    end else begin
      wren_q <= wr_div;  // pulse lines up with ack rising
      for (int i = 0; i < `LED_NUM_BLINK; i++) begin
        if (wr_div[i]) div_q[i] <= wdata_i[`LED_DIV_W-1:0];
      end
      if (wr_en) begin
        case (addr_i)
          `LED_ADDR_LED_SEL: led_sel_q <= wdata_i[`LED_SEL_W-1:0];
          `LED_ADDR_INT_EN:  int_en_q  <= wdata_i[`LED_NUM_BLINK-1:0];
          `LED_ADDR_YELLOW:  yellow_q  <= wdata_i[0];
          default: ;         // read-only or unmapped
        endcase
      end
      // a new pulse wins over a clear in the same cycle
      int_status_q <= (int_status_q & ~int_clr) | cfg.led_int;
      irq_q        <= |(int_status_q & int_en_q);
    end
  end

  // ----------------------------------------
  // read path
  // ----------------------------------------
  always_comb begin
    rd_data = '0;  // unmapped reads zero
    case (addr_i)
      `LED_ADDR_BUILD_ID_LO: rd_data = `LED_BUILD_ID_LO;
      `LED_ADDR_BUILD_ID_HI: rd_data = `LED_BUILD_ID_HI;
      `LED_ADDR_DIV0:        rd_data = data_t'(div_q[0]);
      `LED_ADDR_DIV1:        rd_data = data_t'(div_q[1]);
      `LED_ADDR_DIV2:        rd_data = data_t'(div_q[2]);
      `LED_ADDR_LED_SEL:     rd_data = data_t'(led_sel_q);
      `LED_ADDR_INT_STATUS:  rd_data = data_t'(int_status_q);
      `LED_ADDR_INT_EN:      rd_data = data_t'(int_en_q);
      `LED_ADDR_YELLOW:      rd_data = data_t'(yellow_q);
      default: ;
    endcase
  end

  // captured once per request, held through ack
  always_ff @(posedge clk100_i) begin
    if (access) rdata_q <= rd_data;
  end

  assign rdata_o = rdata_q;
  assign irq_o   = irq_q;

  // ----------------------------------------
  // blinker config and led mux
  // ----------------------------------------
  assign cfg.div0 = div_q[0];
  assign cfg.div1 = div_q[1];
  assign cfg.div2 = div_q[2];
  assign cfg.wren = wren_q;

  always_comb begin
    case (led_sel_q)
      led_sel_t'(0): blue = cfg.led[0];
      led_sel_t'(1): blue = cfg.led[1];
      led_sel_t'(2): blue = cfg.led[2];
      led_sel_t'(3): blue = 1'b0;  // forced off
      led_sel_t'(4): blue = 1'b1;  // forced on
      default:       blue = yellow_q;
    endcase
  end

  assign radio_led_o = {blue, yellow_q};

  // ack only ever answers a request seen on the edge before
  a_ack_needs_req: assert property (@(posedge clk100_i) disable iff (!arst_n_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack_o rose without req_i");

  // one reload pulse per write, even with req held
  a_wren_single: assert property (@(posedge clk100_i) disable iff (!arst_n_i)
    (cfg.wren != '0) |=> (cfg.wren == '0))
    else $error("wren held longer than one cycle");

endmodule

// ==== testbench/led_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "led_ctrl_defs.svh"

module led_ctrl_tb
  import led_ctrl_pkg::*;
();

  localparam int HALF_PERIOD = 20;  // 40 ns clock
  localparam int WAIT_LIMIT  = 32;  // cycles per handshake phase
  localparam int PRE         = `LED_PRESCALE;

  logic        clk100;
  logic        arst_n;
  logic        req;
  logic        we;
  addr_t       addr;
  data_t       wdata;
  logic        ack;
  data_t       rdata;
  logic        irq;
  logic [1:0]  radio_led;  // 1 blue, 0 yellow
  int          errors;
  int          checks;
  int          tests_run;
  event        hang_ev;    // raised by any wait that ran out

  led_ctrl_top i_dut (
    .clk100_i    (clk100   ),
    .arst_n_i    (arst_n   ),
    .req_i       (req      ),
    .we_i        (we       ),
    .addr_i      (addr     ),
    .wdata_i     (wdata    ),
    .ack_o       (ack      ),
    .rdata_o     (rdata    ),
    .irq_o       (irq      ),
    .radio_led_o (radio_led)
  );

  initial begin
    clk100 = 1'b0;
    forever #HALF_PERIOD clk100 = ~clk100;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic data_t width_mask(input int w);
    return data_t'((64'd1 << w) - 1);
  endfunction

  task automatic check_eq(input data_t got, input data_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("ERROR @ %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_hang(input string what);
    $display("TIMEOUT @ %0d ns: gave up waiting for %s", $time, what);
    -> hang_ev;
    forever @(posedge clk100);  // parked until the run ends
  endtask

  task automatic print_test_result(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) $display("[%0d ns] %s: ok", $time, name);
    else $display("[%0d ns] %s: %0d errors", $time, name, errors - err_start);
  endtask

  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while (ack !== level && n < WAIT_LIMIT) begin
      @(negedge clk100);
      n++;
    end
    if (ack !== level) report_hang(what);
  endtask

  task automatic wait_irq(input logic level, input string what);
    int n;
    n = 0;
    while (irq !== level && n < WAIT_LIMIT) begin
      @(negedge clk100);
      n++;
    end
    if (irq !== level) report_hang(what);
  endtask

  // cycles up to the next change of the blue led
  task automatic wait_blue_edge(input int limit, output int cycles);
    logic prev;
    prev   = radio_led[1];
    cycles = 0;
    do begin
      @(negedge clk100);
      cycles++;
    end while (radio_led[1] === prev && cycles < limit);
    if (radio_led[1] === prev) report_hang("an edge on the blue LED");
  endtask

  // ----------------------------------------
  // four-phase register port
  // ----------------------------------------
  task automatic bus_write(input addr_t a, input data_t d);
    @(negedge clk100);
    req   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    wait_ack(1'b1, "ack_o to rise on a write");
    req = 1'b0;  // phase 3
    we  = 1'b0;
    wait_ack(1'b0, "ack_o to fall on a write");
  endtask

  task automatic bus_read(input addr_t a, output data_t d);
    @(negedge clk100);
    req  = 1'b1;
    we   = 1'b0;
    addr = a;
    wait_ack(1'b1, "ack_o to rise on a read");
    d   = rdata;  // valid while ack high
    req = 1'b0;
    wait_ack(1'b0, "ack_o to fall on a read");
  endtask

  task automatic write_read_masked(input addr_t a, input int w, input string what);
    data_t v;
    data_t rd;
    v = $urandom;
    bus_write(a, v);
    bus_read(a, rd);
    check_eq(rd, v & width_mask(w), what);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic reset_identity();
    int    err0;
    data_t rd;
    addr_t unmapped;
    err0 = errors;
    check_eq(data_t'(irq), '0, "irq_o after reset");
    check_eq(data_t'(radio_led), '0, "LEDs after reset");
    bus_read(`LED_ADDR_BUILD_ID_LO, rd);
    check_eq(rd, `LED_BUILD_ID_LO, "BUILD_ID_LO");
    bus_read(`LED_ADDR_BUILD_ID_HI, rd);
    check_eq(rd, `LED_BUILD_ID_HI, "BUILD_ID_HI");
    for (int i = 0; i < `LED_NUM_BLINK; i++) begin
      bus_read(addr_t'(`LED_ADDR_DIV0 + i), rd);
      check_eq(rd, data_t'(`LED_DIV_RESET), $sformatf("DIV%0d reset value", i));
    end
    unmapped = addr_t'(`LED_ADDR_YELLOW + 1 + $urandom_range(6));  // 9 to 15
    bus_read(unmapped, rd);
    check_eq(rd, '0, $sformatf("unmapped address %0d", unmapped));
    print_test_result("reset and identity", err0);
  endtask

  task automatic reg_readback();
    int    err0;
    data_t rd;
    err0 = errors;
    for (int i = 0; i < `LED_NUM_BLINK; i++) begin
      write_read_masked(addr_t'(`LED_ADDR_DIV0 + i), `LED_DIV_W,
                        $sformatf("DIV%0d read-back", i));
    end
    write_read_masked(`LED_ADDR_LED_SEL, `LED_SEL_W, "LED_SEL read-back");
    write_read_masked(`LED_ADDR_INT_EN, `LED_NUM_BLINK, "INT_EN read-back");
    write_read_masked(`LED_ADDR_YELLOW, 1, "YELLOW read-back");
    // identifier is read only
    bus_write(`LED_ADDR_BUILD_ID_LO, $urandom);
    bus_write(`LED_ADDR_BUILD_ID_HI, $urandom);
    bus_read(`LED_ADDR_BUILD_ID_LO, rd);
    check_eq(rd, `LED_BUILD_ID_LO, "BUILD_ID_LO after write");
    bus_read(`LED_ADDR_BUILD_ID_HI, rd);
    check_eq(rd, `LED_BUILD_ID_HI, "BUILD_ID_HI after write");
    bus_write(`LED_ADDR_INT_EN, '0);  // quiet irq for later tests
    print_test_result("register read-back", err0);
  endtask

  task automatic blink_period();
    int err0;
    int d [`LED_NUM_BLINK];
    int cycles;
    int limit;
    err0 = errors;
    for (int i = 0; i < `LED_NUM_BLINK; i++) begin
      d[i] = $urandom_range(6, 1);
      bus_write(addr_t'(`LED_ADDR_DIV0 + i), data_t'(d[i]));
    end
    for (int i = 0; i < `LED_NUM_BLINK; i++) begin
      bus_write(`LED_ADDR_LED_SEL, data_t'(i));
      limit = 4 * (d[i] + 1) * PRE + 16;
      wait_blue_edge(limit, cycles);  // line up on an edge first
      repeat (2) begin
        wait_blue_edge(limit, cycles);
        check_eq(data_t'(cycles), data_t'((d[i] + 1) * PRE),
                 $sformatf("blinker %0d half period, div %0d", i, d[i]));
      end
    end
    print_test_result("blink period", err0);
  endtask

  task automatic blue_select();
    int   err0;
    logic y;
    err0 = errors;
    bus_write(`LED_ADDR_LED_SEL, 3);
    check_eq(data_t'(radio_led[1]), '0, "blue forced off");
    bus_write(`LED_ADDR_LED_SEL, 4);
    check_eq(data_t'(radio_led[1]), 1, "blue forced on");
    for (int s = 5; s < (1 << `LED_SEL_W); s++) begin
      y = ($urandom_range(1) == 1);
      bus_write(`LED_ADDR_YELLOW, data_t'(y));
      bus_write(`LED_ADDR_LED_SEL, data_t'(s));
      check_eq(data_t'(radio_led), data_t'({y, y}), $sformatf("sel %0d yellow", s));
      y = !y;
      bus_write(`LED_ADDR_YELLOW, data_t'(y));
      check_eq(data_t'(radio_led), data_t'({y, y}), $sformatf("sel %0d toggled", s));
    end
    print_test_result("blue select", err0);
  endtask

  task automatic irq_flow();
    int    err0;
    int    ch;
    int    n;
    data_t st;
    err0 = errors;
    bus_write(`LED_ADDR_INT_EN, '0);
    bus_write(`LED_ADDR_INT_STATUS, width_mask(`LED_NUM_BLINK));
    // blinkers still run with the short divisors, so every bit sets
    st = '0;
    n  = 0;
    while (st !== width_mask(`LED_NUM_BLINK) && n < 64) begin
      bus_read(`LED_ADDR_INT_STATUS, st);
      check_eq(data_t'(irq), '0, "irq_o with INT_EN clear");
      n++;
    end
    if (st !== width_mask(`LED_NUM_BLINK)) report_hang("all INT_STATUS bits to set");
    ch = $urandom_range(`LED_NUM_BLINK - 1);
    bus_write(`LED_ADDR_INT_EN, data_t'(1 << ch));
    wait_irq(1'b1, "irq_o to rise after enable");
    // status bit stays set, so irq_o holds
    bus_read(`LED_ADDR_INT_STATUS, st);
    check_eq(data_t'(irq), 1, $sformatf("irq_o held with channel %0d enabled", ch));
    // longest divisor keeps this channel dark for the rest of the run
    bus_write(addr_t'(`LED_ADDR_DIV0 + ch), width_mask(`LED_DIV_W));
    bus_write(`LED_ADDR_INT_STATUS, data_t'(1 << ch));
    bus_read(`LED_ADDR_INT_STATUS, st);
    check_eq(st & data_t'(1 << ch), '0, $sformatf("INT_STATUS bit %0d after clear", ch));
    wait_irq(1'b0, "irq_o to fall after clear");
    // other channels still flagged but masked off
    bus_read(`LED_ADDR_INT_STATUS, st);
    check_eq(st, width_mask(`LED_NUM_BLINK) & ~data_t'(1 << ch),
             "INT_STATUS with only disabled bits set");
    check_eq(data_t'(irq), '0, "irq_o with only disabled bits set");
    print_test_result("interrupts", err0);
  endtask

  // ----------------------------------------
  // run
  // ----------------------------------------
  initial begin
    @(hang_ev);
    $display("Test failures found");
    $finish;
  end

  initial begin
    arst_n    = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    void'($urandom(82260));
    repeat (4) @(posedge clk100);
    @(negedge clk100);
    arst_n = 1'b1;

    reset_identity();
    reg_readback();
    blink_period();
    blue_select();
    irq_flow();

    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
